// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/riscv_pkg.sv
      - hw/alu_dec.sv
      - hw/controller.sv
      - hw/alu.sv
      - hw/reg_file.sv
      - hw/datapath.sv
      - hw/riscv_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_riscv_core.sv

// ==== hw/alu.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "riscv_defines.svh"

module alu (
    input  logic [`RV_XLEN-1:0]   a,
    input  logic [`RV_XLEN-1:0]   b,
    input  riscv_pkg::alu_op_e    op,
    output logic [`RV_XLEN-1:0]   result,
    output riscv_pkg::alu_flags_t flags
);
    import riscv_pkg::*;

    logic                sub;   // sub and both compares use a - b
    logic [`RV_XLEN-1:0] b_eff; // b or ~b
    logic [`RV_XLEN-1:0] sum;
    logic                cout;
    logic                ov;
    logic                lt_s;  // signed a < b
    logic [4:0]          shamt;

    assign sub   = op inside {alu_op_sub, alu_op_slt, alu_op_sltu};
    assign b_eff = sub ? ~b : b;

    // one adder, +1 carry-in completes two's complement
    assign {cout, sum} = {1'b0, a} + {1'b0, b_eff} + {{`RV_XLEN{1'b0}}, sub};

    // operands agree in sign but sum does not
    assign ov    = (a[`RV_XLEN-1] == b_eff[`RV_XLEN-1]) && (sum[`RV_XLEN-1] != a[`RV_XLEN-1]);
    assign lt_s  = sum[`RV_XLEN-1] ^ ov;
    assign shamt = b[4:0]; // upper bits ignored, also for srai imm

    always_comb begin
        case (op)
            alu_op_add,
            alu_op_sub:  result = sum;
            alu_op_and:  result = a & b;
            alu_op_or:   result = a | b;
            alu_op_xor:  result = a ^ b;
            alu_op_sll:  result = a << shamt;
            alu_op_srl:  result = a >> shamt;
            alu_op_sra:  result = $signed(a) >>> shamt;
            alu_op_slt:  result = {{(`RV_XLEN-1){1'b0}}, lt_s};
            alu_op_sltu: result = {{(`RV_XLEN-1){1'b0}}, !cout}; // borrow means a < b
            default:     result = sum;
        endcase
    end

    assign flags = '{
        neg:  result[`RV_XLEN-1],
        zero: (result == '0),
        cout: cout,
        ov:   ov
    };

endmodule

`default_nettype wire

// ==== hw/alu_dec.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "riscv_defines.svh"

module alu_dec (
    input  logic [6:0]         op,
    input  logic [2:0]         func3,
    input  logic [6:0]         func7,
    output riscv_pkg::alu_op_e alu_ctrl
);
    import riscv_pkg::*;

    logic    alt_op;   // instr bit 30
    logic    is_reg;   // r-type, only one that can pick sub
    alu_op_e arith_op; // func3 table shared by r and i type

    assign alt_op = func7[5];
    assign is_reg = (op == `RV_OP_REG);

    always_comb begin
        case (func3)
            3'b000:  arith_op = (alt_op && is_reg) ? alu_op_sub : alu_op_add; // no subi
            3'b001:  arith_op = alu_op_sll;
            3'b010:  arith_op = alu_op_slt;
            3'b011:  arith_op = alu_op_sltu;
            3'b100:  arith_op = alu_op_xor;
            3'b101:  arith_op = alt_op ? alu_op_sra : alu_op_srl; // srai sits in imm[10]
            3'b110:  arith_op = alu_op_or;
            default: arith_op = alu_op_and;
        endcase
    end

    always_comb begin
        case (op)
            `RV_OP_REG,
            `RV_OP_IMM:    alu_ctrl = arith_op;
            `RV_OP_BRANCH: alu_ctrl = alu_op_sub; // rs1 - rs2, controller reads flags
            `RV_OP_LOAD,
            `RV_OP_STORE,
            `RV_OP_JAL:    alu_ctrl = alu_op_add; // address calc, result unused on jal
            default:       alu_ctrl = alu_op_add;
        endcase
    end

    // opcodes outside the subset decode as add and must not go unnoticed
    always_comb begin
        assert final ($isunknown(op) || op inside {`RV_OP_LOAD, `RV_OP_IMM, `RV_OP_STORE,
                `RV_OP_REG, `RV_OP_BRANCH, `RV_OP_JAL})
            else $error("alu_dec: unsupported opcode %h", op);
    end

endmodule

`default_nettype wire

// ==== hw/controller.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "riscv_defines.svh"

module controller (
    input  logic                  arst_n,
    input  logic [31:0]           instr,
    input  riscv_pkg::alu_flags_t alu_flags,
    output logic                  reg_we,
    output logic                  mem_we,
    output riscv_pkg::alu_src_e   alu_src,
    output riscv_pkg::res_src_e   result_src,
    output riscv_pkg::pc_src_e    pc_src,
    output riscv_pkg::imm_src_e   imm_src,
    output riscv_pkg::alu_op_e    alu_ctrl
);
    import riscv_pkg::*;

    logic [6:0] op;
    logic [2:0] func3;
    logic [6:0] func7;
    logic       dec_reg_we; // before reset masking
    logic       dec_mem_we;
    logic       br_taken;   // branch condition met
    pc_src_e    br_pc_src;

    assign op    = instr[6:0];
    assign func3 = instr[14:12];
    assign func7 = instr[31:25];

    alu_dec u_alu_dec (
        .op       (op),
        .func3    (func3),
        .func7    (func7),
        .alu_ctrl (alu_ctrl)
    );

    // branch resolver, alu is doing rs1 - rs2 here
    always_comb begin
        case (func3)
            3'b000:  br_taken = alu_flags.zero;                   // beq
            3'b001:  br_taken = !alu_flags.zero;                  // bne
            3'b100:  br_taken = alu_flags.neg ^ alu_flags.ov;     // blt
            3'b101:  br_taken = !(alu_flags.neg ^ alu_flags.ov);  // bge
            3'b110:  br_taken = !alu_flags.cout;                  // bltu, borrow
            3'b111:  br_taken = alu_flags.cout;                   // bgeu
            default: br_taken = 1'b0;
        endcase
    end

    assign br_pc_src = br_taken ? pc_src_plus_off : pc_src_plus_4;

    // per opcode control word, defaults are a harmless nop
    always_comb begin
        dec_reg_we = 1'b0;
        dec_mem_we = 1'b0;
        alu_src    = alu_src_reg;
        result_src = res_src_alu_out;
        pc_src     = pc_src_plus_4;
        imm_src    = imm_src_itype;
        case (op)
            `RV_OP_LOAD: begin
                dec_reg_we = 1'b1;
                alu_src    = alu_src_ext_imm; // base + offset
                result_src = res_src_read_data;
            end
            `RV_OP_IMM: begin
                dec_reg_we = 1'b1;
                alu_src    = alu_src_ext_imm;
            end
            `RV_OP_STORE: begin
                dec_mem_we = 1'b1;
                alu_src    = alu_src_ext_imm;
                imm_src    = imm_src_stype;
            end
            `RV_OP_REG:    dec_reg_we = 1'b1;
            `RV_OP_BRANCH: begin
                pc_src  = br_pc_src;
                imm_src = imm_src_btype;
            end
            `RV_OP_JAL: begin
                dec_reg_we = 1'b1;
                result_src = res_src_pc_plus_4; // link
                pc_src     = pc_src_plus_off;
                imm_src    = imm_src_jtype;
            end
            default: ;
        endcase
    end

    // nothing commits while in reset
    assign reg_we = dec_reg_we & arst_n;
    assign mem_we = dec_mem_we & arst_n;

    always_comb begin
        assert final (!(reg_we && mem_we))
            else $error("controller: reg_we and mem_we both high");
        assert final ($isunknown(instr) || op != `RV_OP_BRANCH || !(func3 inside {3'd2, 3'd3}))
            else $error("controller: branch with reserved func3 %0d", func3);
    end

endmodule

`default_nettype wire

// ==== hw/datapath.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "riscv_defines.svh"

module datapath (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [31:0]           instr,
    input  logic [31:0]           read_data,
    input  logic                  reg_we,
    input  logic                  mem_we,
    input  riscv_pkg::alu_src_e   alu_src,
    input  riscv_pkg::res_src_e   result_src,
    input  riscv_pkg::pc_src_e    pc_src,
    input  riscv_pkg::imm_src_e   imm_src,
    input  riscv_pkg::alu_op_e    alu_ctrl,
    output riscv_pkg::alu_flags_t alu_flags,
    output logic [31:0]           instr_addr,
    output logic [31:0]           data_addr,
    output logic [31:0]           write_data
);
    import riscv_pkg::*;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_next;
    logic [`RV_XLEN-1:0] pc_plus_4;
    logic [`RV_XLEN-1:0] pc_target; // branch / jal destination
    logic [`RV_XLEN-1:0] imm_ext;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] src_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] result;    // write-back value

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc_next; // one instr per cycle
        end
    end

    assign pc_plus_4 = pc + 32'd4;
    assign pc_target = pc + imm_ext;
    assign pc_next   = (pc_src == pc_src_plus_off) ? pc_target : pc_plus_4;

    // sign extension per format, b and j offsets are even
    always_comb begin
        case (imm_src)
            imm_src_itype: imm_ext = {{20{instr[31]}}, instr[31:20]};
            imm_src_stype: imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_src_btype: imm_ext = {{19{instr[31]}}, instr[31], instr[7],
                                      instr[30:25], instr[11:8], 1'b0};
            default:       imm_ext = {{11{instr[31]}}, instr[31], instr[19:12],
                                      instr[20], instr[30:21], 1'b0}; // jal
        endcase
    end

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (instr[19:15]),
        .rs2      (instr[24:20]),
        .rd       (instr[11:7]),
        .rd_data  (result),
        .we       (reg_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign src_b = (alu_src == alu_src_ext_imm) ? imm_ext : rs2_data;

    alu u_alu (
        .a      (rs1_data),
        .b      (src_b),
        .op     (alu_ctrl),
        .result (alu_result),
        .flags  (alu_flags)
    );

    always_comb begin
        case (result_src)
            res_src_read_data: result = read_data;
            res_src_pc_plus_4: result = pc_plus_4;
            default:           result = alu_result;
        endcase
    end

    assign instr_addr = pc;
    assign data_addr  = alu_result;
    assign write_data = rs2_data; // sw always stores rs2

    // word accesses only, a store address from the alu must be aligned
    a_store_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_we |-> (data_addr[1:0] == 2'b00)
    ) else $error("datapath: misaligned store to %h", data_addr);

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "riscv_defines.svh"

module reg_file (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          rd,
    input  logic [`RV_XLEN-1:0] rd_data,
    input  logic                we,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);
    logic [`RV_XLEN-1:0] regs [32]; // entry 0 kept only so x0 stays observable

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin // writes to x0 dropped
            regs[rd] <= rd_data;
        end
    end

    // two async read ports
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

    // a write aimed at x0 must still leave it zero afterwards
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        (we && rd == 5'd0) |=> (regs[0] == '0)
    ) else $error("reg_file: x0 became %h", regs[0]);

endmodule

`default_nettype wire

// ==== hw/riscv_core.sv ====
`default_nettype none
`timescale 1ns/10ps

module riscv_core (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] instr,
    input  logic [31:0] read_data,
    output logic [31:0] instr_addr,
    output logic [31:0] data_addr,
    output logic [31:0] write_data,
    output logic        mem_we
);
    import riscv_pkg::*;

    logic       reg_we;
    alu_src_e   alu_src;
    res_src_e   result_src;
    pc_src_e    pc_src;
    imm_src_e   imm_src;
    alu_op_e    alu_ctrl;
    alu_flags_t alu_flags; // datapath back to branch resolver

    controller u_controller (
        .arst_n     (arst_n),
        .instr      (instr),
        .alu_flags  (alu_flags),
        .reg_we     (reg_we),
        .mem_we     (mem_we),
        .alu_src    (alu_src),
        .result_src (result_src),
        .pc_src     (pc_src),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl)
    );

    datapath u_datapath (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (instr),
        .read_data  (read_data),
        .reg_we     (reg_we),
        .mem_we     (mem_we),
        .alu_src    (alu_src),
        .result_src (result_src),
        .pc_src     (pc_src),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .alu_flags  (alu_flags),
        .instr_addr (instr_addr),
        .data_addr  (data_addr),
        .write_data (write_data)
    );

endmodule

`default_nettype wire

// ==== hw/riscv_defines.svh ====
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// one data word
`define RV_XLEN 32

// major opcodes, instr[6:0]
`define RV_OP_LOAD   7'b0000011 // lw
`define RV_OP_IMM    7'b0010011 // addi, slti, ..., srai
`define RV_OP_STORE  7'b0100011 // sw
`define RV_OP_REG    7'b0110011 // add, sub, ..., and
`define RV_OP_BRANCH 7'b1100011 // beq .. bgeu
`define RV_OP_JAL    7'b1101111 // jal only, no jalr

// first fetch address after reset release
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== hw/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

    // alu operation, encoding is internal to the core
    typedef enum logic [3:0] {
        alu_op_add  = 4'd0,
        alu_op_sub  = 4'd1,
        alu_op_and  = 4'd2,
        alu_op_or   = 4'd3,
        alu_op_xor  = 4'd4,
        alu_op_sll  = 4'd5,
        alu_op_srl  = 4'd6,
        alu_op_sra  = 4'd7,
        alu_op_slt  = 4'd8,  // signed compare, 0 or 1
        alu_op_sltu = 4'd9   // unsigned compare
    } alu_op_e;

    // second alu operand
    typedef enum logic {
        alu_src_reg     = 1'b0, // rs2
        alu_src_ext_imm = 1'b1  // extended immediate
    } alu_src_e;

    // register write-back value
    typedef enum logic [1:0] {
        res_src_alu_out   = 2'd0,
        res_src_read_data = 2'd1, // lw
        res_src_pc_plus_4 = 2'd2  // jal link
    } res_src_e;

    typedef enum logic {
        pc_src_plus_4   = 1'b0,
        pc_src_plus_off = 1'b1 // taken branch or jal
    } pc_src_e;

    // immediate layout inside the instruction word
    typedef enum logic [1:0] {
        imm_src_itype = 2'd0,
        imm_src_stype = 2'd1,
        imm_src_btype = 2'd2,
        imm_src_jtype = 2'd3
    } imm_src_e;

    // same bit order as the alu flag output, neg on top
    typedef struct packed {
        logic neg;
        logic zero;
        logic cout;
        logic ov;
    } alu_flags_t;

endpackage

`default_nettype wire

// ==== tests/tb_riscv_core.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "riscv_defines.svh"

module tb_riscv_core;

    localparam int          IMEM_WORDS  = 128;
    localparam int          DMEM_WORDS  = 64;
    localparam int          RUN_TIMEOUT = 400; // cycles until the end address
    localparam logic [31:0] NOP         = {12'd0, 5'd0, 3'b000, 5'd0, `RV_OP_IMM}; // addi x0,x0,0

    // what a store in a given slot is meant to carry
    localparam logic [2:0] ST_NONE = 3'd0;
    localparam logic [2:0] ST_COPY = 3'd1; // operand read back by lw
    localparam logic [2:0] ST_ALU  = 3'd2; // r or i type result
    localparam logic [2:0] ST_LINK = 3'd3; // jal return address
    localparam logic [2:0] ST_ZERO = 3'd4; // rs2 = x0

    logic        clk = 1'b0;
    logic        arst_n;
    logic [31:0] instr;
    logic [31:0] read_data;
    logic [31:0] instr_addr;
    logic [31:0] data_addr;
    logic [31:0] write_data;
    logic        mem_we;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] exp_next_pc [IMEM_WORDS]; // per slot, from the branch/jal rules
    logic [31:0] exp_wdata [IMEM_WORDS];
    logic [31:0] exp_daddr [IMEM_WORDS];
    logic [2:0]  store_kind [IMEM_WORDS];
    logic [31:0] operand [8];
    logic [31:0] lfsr_state;
    logic [31:0] end_pc;
    int          asm_word;
    int          errors = 0;

    logic [6:0]  pc_word;
    logic [2:0]  cur_kind;
    logic [31:0] cur_wdata;
    logic [31:0] cur_daddr;
    logic        pc_armed;    // one full cycle out of reset seen
    logic [31:0] prev_exp_pc;

    always #4 clk = ~clk; // 8 ns

    riscv_core dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (instr),
        .read_data  (read_data),
        .instr_addr (instr_addr),
        .data_addr  (data_addr),
        .write_data (write_data),
        .mem_we     (mem_we)
    );

    // memory models, word addressed
    assign pc_word   = instr_addr[8:2];
    assign instr     = imem[pc_word];
    assign read_data = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (mem_we) begin
            dmem[data_addr[7:2]] <= write_data;
        end
    end

    assign cur_kind  = store_kind[pc_word];
    assign cur_wdata = exp_wdata[pc_word];
    assign cur_daddr = exp_daddr[pc_word];

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_armed    <= 1'b0;
            prev_exp_pc <= `RV_RESET_PC;
        end else begin
            pc_armed    <= 1'b1;
            prev_exp_pc <= exp_next_pc[pc_word]; // where this slot must lead
        end
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]}; // one step per bit
        end
    endtask

    function automatic logic [31:0] r_type(input logic alt, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE}; // sw
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    // rv32i semantics of the func3 table, alt picks sub or sra
    function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic put_instr(input logic [31:0] word, input int next_off,
                             input logic [2:0] kind, input logic [31:0] wdata,
                             input logic [31:0] daddr);
        imem[asm_word]        = word;
        exp_next_pc[asm_word] = 32'(asm_word * 4 + next_off);
        store_kind[asm_word]  = kind;
        exp_wdata[asm_word]   = wdata;
        exp_daddr[asm_word]   = daddr;
        asm_word++;
    endtask

    // assembles the program and walks it on a register model at the same time
    task automatic build_program();
        logic [31:0] mreg [32];
        logic [31:0] res;
        logic [31:0] imm_bits;
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        taken;
        logic [31:0] jal_pc;
        int          n;

        lfsr_state = 32'd66421;
        asm_word   = 0;
        n          = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            put_instr(NOP, 4, ST_NONE, '0, '0);
        end
        asm_word = 0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'(i) * 32'h9e37_79b9; // scrambled by the whole index
        end
        for (int i = 0; i < 32; i++) begin
            mreg[i] = '0;
        end
        for (int k = 0; k < 8; k++) begin
            take_bits(32, operand[k]);
            dmem[k] = operand[k];
        end

        // a store waits at the reset pc while arst_n is low
        put_instr(s_type(12'd152, 5'd0, 5'd0), 4, ST_ZERO, '0, 32'd152);

        // lw x1..x8, then copy each to words 8..15
        for (int k = 0; k < 8; k++) begin
            put_instr(i_type(12'(4 * k), 5'd0, 3'b010, 5'(k + 1), `RV_OP_LOAD), 4,
                      ST_NONE, '0, '0);
            mreg[k + 1] = operand[k];
        end
        for (int k = 0; k < 8; k++) begin
            put_instr(s_type(12'(32 + 4 * k), 5'(k + 1), 5'd0), 4, ST_COPY, operand[k],
                      32'(32 + 4 * k));
        end

        // ten r-type ops into x9, each stored to the result area
        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f == 0 || f == 5) begin
                    rs1 = 5'(1 + n % 8);
                    rs2 = 5'(1 + (n + 3) % 8);
                    res = alu_expect(3'(f), alt[0], mreg[rs1], mreg[rs2]);
                    put_instr(r_type(alt[0], rs2, rs1, 3'(f), 5'd9), 4, ST_NONE, '0, '0);
                    put_instr(s_type(12'(64 + 4 * n), 5'd9, 5'd0), 4, ST_ALU, res,
                              32'(64 + 4 * n));
                    n++;
                end
            end
        end

        // nine i-type ops into x10, no subi, srai sits in imm[10]
        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f == 5) begin
                    rs1 = 5'(1 + n % 8);
                    take_bits(12, imm_bits);
                    imm = imm_bits[11:0];
                    if (f == 1 || f == 5) begin
                        imm = {1'b0, alt[0], 5'd0, imm_bits[4:0]};
                    end
                    res = alu_expect(3'(f), (f == 5) && alt[0], mreg[rs1],
                                     {{20{imm[11]}}, imm});
                    put_instr(i_type(imm, rs1, 3'(f), 5'd10, `RV_OP_IMM), 4, ST_NONE, '0, '0);
                    put_instr(s_type(12'(64 + 4 * n), 5'd10, 5'd0), 4, ST_ALU, res,
                              32'(64 + 4 * n));
                    n++;
                end
            end
        end

        // each branch kind twice, offset 8 jumps the nop
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                for (int p = 0; p < 2; p++) begin
                    if (f < 2) begin
                        rs1 = 5'd1;
                        rs2 = (p == 0) ? 5'd1 : 5'd2; // equal, then different
                    end else begin
                        rs1 = (p == 0) ? 5'd1 : 5'd2; // swapped order flips the outcome
                        rs2 = (p == 0) ? 5'd2 : 5'd1;
                    end
                    taken = branch_taken(3'(f), mreg[rs1], mreg[rs2]);
                    put_instr(b_type(13'd8, rs2, rs1, 3'(f)), taken ? 8 : 4, ST_NONE, '0, '0);
                    put_instr(NOP, 4, ST_NONE, '0, '0);
                end
            end
        end

        // ori x0 tries to leave an odd value behind
        put_instr(i_type(12'd1, 5'd1, 3'b110, 5'd0, `RV_OP_IMM), 4, ST_NONE, '0, '0);
        put_instr(s_type(12'd144, 5'd0, 5'd0), 4, ST_ZERO, '0, 32'd144);
        jal_pc = 32'(asm_word * 4);
        put_instr(j_type(21'd8, 5'd11), 8, ST_NONE, '0, '0);
        put_instr(NOP, 4, ST_NONE, '0, '0); // skipped
        put_instr(s_type(12'd148, 5'd11, 5'd0), 4, ST_LINK, jal_pc + 32'd4, 32'd148);
        end_pc = 32'(asm_word * 4);
        put_instr(j_type(21'd0, 5'd0), 0, ST_NONE, '0, '0); // parks here
    endtask

    a_reset_pc: assert property (@(posedge clk) !arst_n |-> instr_addr == `RV_RESET_PC)
        else begin
            errors++;
            $display("Fail instr_addr: expected %h, got %h", `RV_RESET_PC, $sampled(instr_addr));
        end

    a_reset_no_store: assert property (@(posedge clk) !arst_n |-> !mem_we)
        else begin
            errors++;
            $display("Fail mem_we: expected 0, got %h", $sampled(mem_we));
        end

    // first edge after release still fetches from the reset pc
    a_release_pc: assert property (@(posedge clk) $rose(arst_n) |-> instr_addr == `RV_RESET_PC)
        else begin
            errors++;
            $display("Fail instr_addr: expected %h, got %h", `RV_RESET_PC, $sampled(instr_addr));
        end

    a_next_pc: assert property (
        @(posedge clk) disable iff (!arst_n)
        pc_armed |-> instr_addr == prev_exp_pc
    ) else begin
        errors++;
        $display("Fail instr_addr: expected %h, got %h", $sampled(prev_exp_pc),
                 $sampled(instr_addr));
    end

    a_store_enable: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_we == (cur_kind != ST_NONE)
    ) else begin
        errors++;
        $display("Fail mem_we: expected %h, got %h", $sampled(cur_kind != ST_NONE),
                 $sampled(mem_we));
    end

    a_store_addr: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_we |-> data_addr == cur_daddr
    ) else begin
        errors++;
        $display("Fail data_addr: expected %h, got %h", $sampled(cur_daddr), $sampled(data_addr));
    end

    a_alu_store: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_we && cur_kind == ST_ALU) |-> write_data == cur_wdata
    ) else begin
        errors++;
        $display("Fail write_data: expected %h, got %h", $sampled(cur_wdata),
                 $sampled(write_data));
    end

    a_operand_copy: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_we && cur_kind == ST_COPY) |-> write_data == cur_wdata
    ) else begin
        errors++;
        $display("Fail write_data: expected %h, got %h", $sampled(cur_wdata),
                 $sampled(write_data));
    end

    a_link_store: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_we && cur_kind == ST_LINK) |-> write_data == cur_wdata
    ) else begin
        errors++;
        $display("Fail write_data: expected %h, got %h", $sampled(cur_wdata),
                 $sampled(write_data));
    end

    a_zero_store: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_we && cur_kind == ST_ZERO) |-> write_data == 32'd0
    ) else begin
        errors++;
        $display("Fail write_data: expected %h, got %h", 32'd0, $sampled(write_data));
    end

    initial begin
        int   cycles;
        logic reached;

        arst_n = 1'b0;
        build_program();
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;

        reached = 1'b0;
        cycles  = 0;
        while (!reached && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            reached = (instr_addr == end_pc);
            cycles++;
        end
        if (!reached) begin
            errors++;
            $display("program never reached its end address %h within %0d cycles", end_pc,
                     RUN_TIMEOUT);
        end
        repeat (3) @(negedge clk); // a few turns of the final self loop

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/riscv_pkg.sv
hw/alu_dec.sv
hw/controller.sv
hw/alu.sv
hw/reg_file.sv
hw/datapath.sv
hw/riscv_core.sv
tests/tb_riscv_core.sv
